/* mipsPipeline.f */
+incdir+include
verilog/mipsPkg.sv
verilog/controlDecoder.sv
verilog/registerFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/hazardUnit.sv
verilog/mipsPipeline.sv
verif/mipsPipelineTb.sv

/* Bender.yml */
package:
  name: mipsPipeline

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/mipsPkg.sv
      - verilog/controlDecoder.sv
      - verilog/registerFile.sv
      - verilog/decodeStage.sv
      - verilog/executeStage.sv
      - verilog/hazardUnit.sv
      - verilog/mipsPipeline.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/mipsPipelineTb.sv

/* verif/mipsPipelineTb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mipsCore_cfg.svh"

module mipsPipelineTb;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 2;
    localparam int MAX_INSTRS = 60;
    localparam int CYCLES_PER_INSTR = 3;
    localparam int WATCHDOG_NS = (RESET_CYCLES + MAX_INSTRS * CYCLES_PER_INSTR) * CLK_PERIOD;
    localparam int IMEM_WORDS = 64;
    localparam int MEM_WORDS = 1 << (`MIPS_MEM_ADDR_BITS - 2);
    localparam int MAX_STORES = 32;
    localparam logic [31:0] RESET_PC = `MIPS_RESET_PC;
    localparam logic [23:0] SENTINEL_PAGE = 24'h00003F;  // Skipped-path stores go here

    logic                clk;
    logic                reset;
    logic [31:0]         imemAddr;
    mipsPkg::instrT      imemData;
    mipsPkg::dataMemReqT dmemReq;
    logic [31:0]         dmemReadData;
    logic                halt;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];
    logic [31:0] fetchOffset;
    logic [31:0] expAddr [MAX_STORES];
    logic [31:0] expData [MAX_STORES];
    int          expCount;
    int          storeIdx;
    integer      seed;

    mipsPipeline dut (
        .clk         (clk),
        .reset       (reset),
        .imemAddr    (imemAddr),
        .imemData    (imemData),
        .dmemReq     (dmemReq),
        .dmemReadData(dmemReadData),
        .halt        (halt)
    );

    function automatic logic [11:0] memIndex(input logic [31:0] addr);
        memIndex = addr[`MIPS_MEM_ADDR_BITS-1:2];
    endfunction

    ////////////////////////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////////////////////////

    assign fetchOffset = imemAddr - RESET_PC;
    assign imemData = (fetchOffset < IMEM_WORDS * 4) ? imem[fetchOffset >> 2] : '0;
    assign dmemReadData = dmem[memIndex(dmemReq.addr)];

    always @(posedge clk) begin
        if (dmemReq.write) begin
            dmem[memIndex(dmemReq.addr)] <= dmemReq.writeData;
        end
        if (!reset && dmemReq.write) begin
            storeIdx <= storeIdx + 1;   // Store order, not cycle count
        end
    end

    ////////////////////////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////////////////////////

    task automatic stopWithFailure();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string testName, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("FAILED %s: expected 0x%08h, actual 0x%08h", testName, expected, actual);
        stopWithFailure();
    endtask

    task automatic reportError(input string what);
        $display("ERROR: %s", what);
        stopWithFailure();
    endtask

    ////////////////////////////////////////////////////////////
    // Program and golden model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] encodeR(input mipsPkg::functT fn, input logic [4:0] rd,
                                            input logic [4:0] rs, input logic [4:0] rt);
        encodeR = {mipsPkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeI(input mipsPkg::opcodeT op, input logic [4:0] rt,
                                            input logic [4:0] rs, input logic [15:0] imm);
        encodeI = {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encodeJ(input int index);
        logic [31:0] target;
        target = (RESET_PC + 32'(index * 4)) >> 2;
        encodeJ = {mipsPkg::OP_J, target[25:0]};
    endfunction

    task automatic loadProgram();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = '0;   // nop
        end
        imem[0]  = encodeI(mipsPkg::OP_ADDI, 1, 0, 16'h0123);
        imem[1]  = encodeI(mipsPkg::OP_ADDI, 2, 1, 16'hFFFB);   // r1 from memory stage
        imem[2]  = encodeR(mipsPkg::FN_ADD, 3, 1, 2);
        imem[3]  = encodeI(mipsPkg::OP_SW, 3, 0, 16'h0200);
        imem[4]  = encodeR(mipsPkg::FN_SUB, 4, 3, 1);
        imem[5]  = encodeI(mipsPkg::OP_LUI, 5, 0, 16'h8001);
        imem[6]  = encodeI(mipsPkg::OP_ORI, 5, 5, 16'hF0F0);
        imem[7]  = encodeI(mipsPkg::OP_SW, 5, 0, 16'h0204);
        imem[8]  = encodeR(mipsPkg::FN_AND, 6, 5, 3);
        imem[9]  = encodeR(mipsPkg::FN_OR, 7, 6, 4);
        imem[10] = encodeR(mipsPkg::FN_SLT, 8, 5, 1);
        imem[11] = encodeR(mipsPkg::FN_SLT, 9, 1, 5);
        imem[12] = encodeI(mipsPkg::OP_SW, 7, 0, 16'h0208);
        imem[13] = encodeI(mipsPkg::OP_SW, 8, 0, 16'h020C);
        imem[14] = encodeI(mipsPkg::OP_SW, 9, 0, 16'h0210);
        // Load-use pairs
        imem[15] = encodeI(mipsPkg::OP_LW, 10, 0, 16'h0100);
        imem[16] = encodeR(mipsPkg::FN_ADD, 11, 10, 1);
        imem[17] = encodeI(mipsPkg::OP_SW, 11, 0, 16'h0214);
        imem[18] = encodeI(mipsPkg::OP_LW, 12, 0, 16'h0104);
        imem[19] = encodeI(mipsPkg::OP_SW, 12, 0, 16'h0218);
        // Branches and jump
        imem[20] = encodeI(mipsPkg::OP_LW, 13, 0, 16'h0100);
        imem[21] = encodeI(mipsPkg::OP_BEQ, 10, 13, 16'h0001);  // Taken after stalling on the load
        imem[22] = encodeI(mipsPkg::OP_SW, 1, 0, 16'h3F00);
        imem[23] = encodeI(mipsPkg::OP_BEQ, 2, 1, 16'h0001);    // Not taken
        imem[24] = encodeI(mipsPkg::OP_SW, 2, 0, 16'h021C);
        imem[25] = encodeI(mipsPkg::OP_ADDI, 14, 0, 16'h0123);
        imem[26] = encodeI(mipsPkg::OP_BEQ, 1, 14, 16'h0002);   // Taken after stalling on the addi
        imem[27] = encodeI(mipsPkg::OP_SW, 1, 0, 16'h3F04);
        imem[28] = encodeI(mipsPkg::OP_SW, 1, 0, 16'h3F08);
        imem[29] = encodeJ(31);
        imem[30] = encodeI(mipsPkg::OP_SW, 1, 0, 16'h3F0C);
        imem[31] = encodeI(mipsPkg::OP_ADDI, 0, 0, 16'h0055);   // Discarded write to r0
        imem[32] = encodeI(mipsPkg::OP_SW, 0, 0, 16'h0220);
        imem[33] = encodeI(mipsPkg::OP_SW, 14, 0, 16'h0224);
        imem[34] = {mipsPkg::OP_HALT, 26'd0};
        imem[35] = encodeI(mipsPkg::OP_SW, 1, 0, 16'h3F10);
    endtask

    // Sequential ISA model stepping one instruction at a time
    task automatic buildGolden();
        logic [31:0] r [32];
        logic [31:0] m [MEM_WORDS];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sImm;
        logic        halted;
        int          steps;
        m = dmem;
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        pc = RESET_PC;
        halted = 1'b0;
        steps = 0;
        expCount = 0;
        while (!halted && steps < MAX_INSTRS) begin
            w = imem[(pc - RESET_PC) >> 2];
            a = r[w[25:21]];
            b = r[w[20:16]];
            sImm = {{16{w[15]}}, w[15:0]};
            pc = pc + 32'd4;
            case (w[31:26])
                mipsPkg::OP_RTYPE: begin
                    case (w[5:0])
                        mipsPkg::FN_ADD: r[w[15:11]] = a + b;
                        mipsPkg::FN_SUB: r[w[15:11]] = a - b;
                        mipsPkg::FN_AND: r[w[15:11]] = a & b;
                        mipsPkg::FN_OR:  r[w[15:11]] = a | b;
                        mipsPkg::FN_SLT: r[w[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ;
                    endcase
                end
                mipsPkg::OP_ADDI: r[w[20:16]] = a + sImm;
                mipsPkg::OP_ORI:  r[w[20:16]] = a | {16'b0, w[15:0]};
                mipsPkg::OP_LUI:  r[w[20:16]] = {w[15:0], 16'b0};
                mipsPkg::OP_LW:   r[w[20:16]] = m[memIndex(a + sImm)];
                mipsPkg::OP_SW: begin
                    m[memIndex(a + sImm)] = b;
                    expAddr[expCount] = a + sImm;
                    expData[expCount] = b;
                    expCount++;
                end
                mipsPkg::OP_BEQ:  if (a == b) pc = pc + {sImm[29:0], 2'b00};
                mipsPkg::OP_J:    pc = {pc[31:28], w[25:0], 2'b00};
                mipsPkg::OP_HALT: halted = 1'b1;
                default: ;
            endcase
            r[0] = '0;
            steps++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Sampled mid-cycle after the reset state settles
    resetPc: assert property (@(negedge clk) (reset || $fell(reset)) |-> imemAddr == RESET_PC)
        else reportMismatch("reset fetch address", RESET_PC, $sampled(imemAddr));
    resetQuiet: assert property (@(negedge clk)
        (reset || $fell(reset)) |-> !halt && !dmemReq.write)
        else reportError("halt or a store was active during reset");

    storeCount: assert property (@(posedge clk) disable iff (reset)
        dmemReq.write |-> storeIdx < expCount)
        else reportError("the core issued more stores than the golden model expects");
    storeAddress: assert property (@(posedge clk) disable iff (reset)
        dmemReq.write |-> dmemReq.addr == expAddr[storeIdx])
        else reportMismatch($sformatf("store %0d address", $sampled(storeIdx)),
                            expAddr[$sampled(storeIdx)], $sampled(dmemReq.addr));
    storeValue: assert property (@(posedge clk) disable iff (reset)
        dmemReq.write |-> dmemReq.writeData == expData[storeIdx])
        else reportMismatch($sformatf("store %0d data", $sampled(storeIdx)),
                            expData[$sampled(storeIdx)], $sampled(dmemReq.writeData));
    skippedPath: assert property (@(posedge clk) disable iff (reset)
        dmemReq.write |-> dmemReq.addr[31:8] != SENTINEL_PAGE)
        else reportError($sformatf("a store from a skipped path reached address 0x%08h",
                                   $sampled(dmemReq.addr)));

    haltSticky: assert property (@(posedge clk) disable iff (reset) halt |=> halt)
        else reportError("halt dropped before reset");
    haltNoStore: assert property (@(posedge clk) disable iff (reset) halt |-> !dmemReq.write)
        else reportError("a store was issued after halt");
    haltPcFrozen: assert property (@(posedge clk) disable iff (reset)
        halt |=> $stable(imemAddr))
        else reportError("the fetch address moved after halt");

    ////////////////////////////////////////////////////////////
    // Clock, stimulus and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        storeIdx = 0;
        seed = 32'h0b05f5e4;
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = $random(seed);
        end
        loadProgram();
        buildGolden();   // Before the DUT touches data memory
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        wait (halt === 1'b1);
        repeat (4) @(posedge clk);   // Post-halt checks get a few cycles
        if (storeIdx == expCount) begin
            $display("test passed");
            $finish;
        end else begin
            reportMismatch("store count at halt", expCount, storeIdx);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        reportError("watchdog expired before the core halted");
    end

endmodule

`default_nettype wire

/* verilog/mipsPipeline.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mipsCore_cfg.svh"

module mipsPipeline (
    input  logic                   clk,
    input  logic                   reset,
    output logic [`MIPS_XLEN-1:0]  imemAddr,
    input  mipsPkg::instrT         imemData,
    output mipsPkg::dataMemReqT    dmemReq,
    input  logic [`MIPS_XLEN-1:0]  dmemReadData,
    output logic                   halt
);

    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] pcPlus4;
    logic [`MIPS_XLEN-1:0] nextPc;
    logic [`MIPS_XLEN-1:0] decPcPlus4;
    logic [`MIPS_XLEN-1:0] branchTarget;
    logic [`MIPS_XLEN-1:0] jumpTarget;
    logic [`MIPS_XLEN-1:0] execResult;
    logic [`MIPS_XLEN-1:0] execStore;
    logic [`MIPS_XLEN-1:0] writeBack;

    mipsPkg::instrT   decInstr;
    mipsPkg::decExecT decBundle;    // Built in decode
    mipsPkg::decExecT execBundle;
    mipsPkg::execMemT memBundle;
    mipsPkg::memWbT   wbBundle;
    mipsPkg::fwdSelT  fwdExecA;
    mipsPkg::fwdSelT  fwdExecB;

    logic decBranch;
    logic decJump;
    logic branchTaken;
    logic fwdDecA;
    logic fwdDecB;
    logic stall;
    logic flushFetch;
    logic flushExec;
    logic halting;

    ////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////

    assign imemAddr = pc;
    assign pcPlus4 = pc + `MIPS_XLEN'd4;
    assign nextPc = decJump ? jumpTarget : (branchTaken ? branchTarget : pcPlus4);

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            pc <= `MIPS_RESET_PC;
        end else if (!stall) begin
            pc <= nextPc;
        end
    end

    // Halt or redirect loads a nop into decode
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            decInstr   <= '0;
            decPcPlus4 <= `MIPS_RESET_PC;
        end else if (flushFetch || halting) begin
            decInstr <= '0;
        end else if (!stall) begin
            decInstr   <= imemData;
            decPcPlus4 <= pcPlus4;
        end
    end

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    controlDecoder ctrlDec (
        .instr (decInstr),
        .ctrl  (decBundle.ctrl),
        .branch(decBranch),
        .jump  (decJump)
    );

    assign decBundle.rs = decInstr.r.rs;
    assign decBundle.rt = decInstr.r.rt;

    decodeStage decode (
        .clk         (clk),
        .reset       (reset),
        .instr       (decInstr),
        .pcPlus4     (decPcPlus4),
        .zeroExtend  (decBundle.ctrl.zeroExtend),
        .regDst      (!decBundle.ctrl.aluSrcImm),   // R-format writes rd
        .branch      (decBranch),
        .wbAddr      (wbBundle.dest),
        .wbEnable    (wbBundle.ctrl.regWrite),
        .wbData      (writeBack),
        .memResult   (memBundle.aluResult),
        .fwdA        (fwdDecA),
        .fwdB        (fwdDecB),
        .operandA    (decBundle.opA),
        .operandB    (decBundle.opB),
        .immExt      (decBundle.imm),
        .destAddr    (decBundle.dest),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget),
        .jumpTarget  (jumpTarget)
    );

    assign halting = decBundle.ctrl.halt || execBundle.ctrl.halt ||
                     memBundle.ctrl.halt || wbBundle.ctrl.halt || halt;

    hazardUnit hazard (
        .decRs      (decInstr.r.rs),
        .decRt      (decInstr.r.rt),
        .decBranch  (decBranch),
        .decJump    (decJump),
        .decUsesRt  (!decBundle.ctrl.aluSrcImm || decBundle.ctrl.memWrite),
        .execBundle (execBundle),
        .memDest    (memBundle.dest),
        .memCtrl    (memBundle.ctrl),
        .wbDest     (wbBundle.dest),
        .wbCtrl     (wbBundle.ctrl),
        .branchTaken(branchTaken),
        .halting    (halting),
        .fwdExecA   (fwdExecA),
        .fwdExecB   (fwdExecB),
        .fwdDecA    (fwdDecA),
        .fwdDecB    (fwdDecB),
        .stall      (stall),
        .flushFetch (flushFetch),
        .flushExec  (flushExec)
    );

    ////////////////////////////////////////////////////////////
    // Execute, memory, writeback
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            execBundle <= '0;
        end else begin
            execBundle <= flushExec ? '0 : decBundle;
        end
    end

    executeStage execute (
        .bundle   (execBundle),
        .memResult(memBundle.aluResult),
        .wbResult (writeBack),
        .fwdA     (fwdExecA),
        .fwdB     (fwdExecB),
        .result   (execResult),
        .storeData(execStore)
    );

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            memBundle <= '0;
            wbBundle  <= '0;
        end else begin
            memBundle <= '{ctrl: execBundle.ctrl, aluResult: execResult,
                           storeData: execStore, dest: execBundle.dest};
            wbBundle  <= '{ctrl: memBundle.ctrl, aluResult: memBundle.aluResult,
                           loadData: dmemReadData, dest: memBundle.dest};
        end
    end

    assign dmemReq = '{addr: memBundle.aluResult, writeData: memBundle.storeData,
                       write: memBundle.ctrl.memWrite};

    assign writeBack = wbBundle.ctrl.memToReg ? wbBundle.loadData : wbBundle.aluResult;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            halt <= 1'b0;
        end else if (wbBundle.ctrl.halt) begin
            halt <= 1'b1;   // Sticky until reset
        end
    end

    // Every store is older than the halt, so none may follow it
    assert property (@(posedge clk) disable iff (reset) halt |-> !dmemReq.write)
        else $error("mipsPipeline: store issued after halt");

endmodule

`default_nettype wire

/* verilog/hazardUnit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mipsCore_cfg.svh"

module hazardUnit (
    input  logic [`MIPS_REG_ADDR_W-1:0] decRs,
    input  logic [`MIPS_REG_ADDR_W-1:0] decRt,
    input  logic                        decBranch,
    input  logic                        decJump,
    input  logic                        decUsesRt,
    input  mipsPkg::decExecT            execBundle,
    input  logic [`MIPS_REG_ADDR_W-1:0] memDest,
    input  mipsPkg::ctrlT               memCtrl,
    input  logic [`MIPS_REG_ADDR_W-1:0] wbDest,
    input  mipsPkg::ctrlT               wbCtrl,
    input  logic                        branchTaken,
    input  logic                        halting,
    output mipsPkg::fwdSelT             fwdExecA,
    output mipsPkg::fwdSelT             fwdExecB,
    output logic                        fwdDecA,
    output logic                        fwdDecB,
    output logic                        stall,
    output logic                        flushFetch,
    output logic                        flushExec
);

    logic loadUse;
    logic branchOnExec;
    logic branchOnLoad;
    logic dataHazard;

    // Source matches a live destination other than r0
    function automatic logic hits(
        input logic [`MIPS_REG_ADDR_W-1:0] src,
        input logic [`MIPS_REG_ADDR_W-1:0] dst,
        input logic                        writes
    );
        hits = writes && (src != '0) && (src == dst);
    endfunction

    // Memory stage holds the younger result, so it wins
    assign fwdExecA = hits(execBundle.rs, memDest, memCtrl.regWrite) ? mipsPkg::FWD_MEM :
                      hits(execBundle.rs, wbDest, wbCtrl.regWrite)   ? mipsPkg::FWD_WB  :
                                                                       mipsPkg::FWD_NONE;
    assign fwdExecB = hits(execBundle.rt, memDest, memCtrl.regWrite) ? mipsPkg::FWD_MEM :
                      hits(execBundle.rt, wbDest, wbCtrl.regWrite)   ? mipsPkg::FWD_WB  :
                                                                       mipsPkg::FWD_NONE;

    assign fwdDecA = hits(decRs, memDest, memCtrl.regWrite);
    assign fwdDecB = hits(decRt, memDest, memCtrl.regWrite);

    ////////////////////////////////////////////////////////////
    // Stalls
    ////////////////////////////////////////////////////////////

    assign loadUse = execBundle.ctrl.memToReg &&
                     (hits(decRs, execBundle.dest, 1'b1) ||
                      (decUsesRt && hits(decRt, execBundle.dest, 1'b1)));

    // Comparator sits in decode, so an ALU result one stage ahead is too late
    assign branchOnExec = decBranch &&
                          (hits(decRs, execBundle.dest, execBundle.ctrl.regWrite) ||
                           hits(decRt, execBundle.dest, execBundle.ctrl.regWrite));
    assign branchOnLoad = decBranch && memCtrl.memToReg &&
                          (hits(decRs, memDest, 1'b1) || hits(decRt, memDest, 1'b1));

    assign dataHazard = loadUse || branchOnExec || branchOnLoad;

    assign stall = dataHazard || halting;
    assign flushExec = dataHazard;                           // Bubble into execute
    assign flushFetch = (branchTaken || decJump) && !stall;  // Wrong-path fetch

endmodule

`default_nettype wire

/* verilog/executeStage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mipsCore_cfg.svh"

module executeStage (
    input  mipsPkg::decExecT      bundle,
    input  logic [`MIPS_XLEN-1:0] memResult,
    input  logic [`MIPS_XLEN-1:0] wbResult,
    input  mipsPkg::fwdSelT       fwdA,
    input  mipsPkg::fwdSelT       fwdB,
    output logic [`MIPS_XLEN-1:0] result,
    output logic [`MIPS_XLEN-1:0] storeData
);

    logic [`MIPS_XLEN-1:0] srcA;
    logic [`MIPS_XLEN-1:0] srcB;
    logic [`MIPS_XLEN-1:0] aluOut;

    function automatic logic [`MIPS_XLEN-1:0] pickOperand(
        input mipsPkg::fwdSelT       sel,
        input logic [`MIPS_XLEN-1:0] regValue,
        input logic [`MIPS_XLEN-1:0] memValue,
        input logic [`MIPS_XLEN-1:0] wbValue
    );
        case (sel)
            mipsPkg::FWD_MEM: pickOperand = memValue;
            mipsPkg::FWD_WB:  pickOperand = wbValue;
            default:          pickOperand = regValue;
        endcase
    endfunction

    assign srcA = pickOperand(fwdA, bundle.opA, memResult, wbResult);
    assign storeData = pickOperand(fwdB, bundle.opB, memResult, wbResult);
    assign srcB = bundle.ctrl.aluSrcImm ? bundle.imm : storeData;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (bundle.ctrl.aluOp)
            mipsPkg::ALU_AND: aluOut = srcA & srcB;
            mipsPkg::ALU_OR:  aluOut = srcA | srcB;
            mipsPkg::ALU_ADD: aluOut = srcA + srcB;
            mipsPkg::ALU_SUB: aluOut = srcA - srcB;
            mipsPkg::ALU_SLT: aluOut = {{(`MIPS_XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            default:          aluOut = '0;
        endcase
    end

    assign result = bundle.ctrl.immToReg ? {bundle.imm[15:0], 16'b0} : aluOut; // lui

endmodule

`default_nettype wire

/* verilog/decodeStage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mipsCore_cfg.svh"

module decodeStage (
    input  logic                        clk,
    input  logic                        reset,
    input  mipsPkg::instrT              instr,
    input  logic [`MIPS_XLEN-1:0]       pcPlus4,
    input  logic                        zeroExtend,
    input  logic                        regDst,
    input  logic                        branch,
    input  logic [`MIPS_REG_ADDR_W-1:0] wbAddr,
    input  logic                        wbEnable,
    input  logic [`MIPS_XLEN-1:0]       wbData,
    input  logic [`MIPS_XLEN-1:0]       memResult,
    input  logic                        fwdA,
    input  logic                        fwdB,
    output logic [`MIPS_XLEN-1:0]       operandA,
    output logic [`MIPS_XLEN-1:0]       operandB,
    output logic [`MIPS_XLEN-1:0]       immExt,
    output logic [`MIPS_REG_ADDR_W-1:0] destAddr,
    output logic                        branchTaken,
    output logic [`MIPS_XLEN-1:0]       branchTarget,
    output logic [`MIPS_XLEN-1:0]       jumpTarget
);

    logic [`MIPS_XLEN-1:0] cmpA;
    logic [`MIPS_XLEN-1:0] cmpB;

    registerFile regs (
        .clk        (clk),
        .reset      (reset),
        .readAddrA  (instr.r.rs),
        .readAddrB  (instr.r.rt),
        .writeAddr  (wbAddr),
        .writeEnable(wbEnable),
        .writeData  (wbData),
        .readDataA  (operandA),
        .readDataB  (operandB)
    );

    assign immExt = zeroExtend ? {16'b0, instr.i.imm} : {{16{instr.i.imm[15]}}, instr.i.imm};
    assign destAddr = regDst ? instr.r.rd : instr.r.rt;

    // beq resolves here, with the ALU result in memory bypassed in
    assign cmpA = fwdA ? memResult : operandA;
    assign cmpB = fwdB ? memResult : operandB;
    assign branchTaken = branch && (cmpA == cmpB);

    assign branchTarget = pcPlus4 + {immExt[`MIPS_XLEN-3:0], 2'b00};
    assign jumpTarget = {pcPlus4[31:28], instr.i.rs, instr.i.rt, instr.i.imm, 2'b00};

endmodule

`default_nettype wire

/* verilog/registerFile.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mipsCore_cfg.svh"

module registerFile (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`MIPS_REG_ADDR_W-1:0] readAddrA,
    input  logic [`MIPS_REG_ADDR_W-1:0] readAddrB,
    input  logic [`MIPS_REG_ADDR_W-1:0] writeAddr,
    input  logic                        writeEnable,
    input  logic [`MIPS_XLEN-1:0]       writeData,
    output logic [`MIPS_XLEN-1:0]       readDataA,
    output logic [`MIPS_XLEN-1:0]       readDataB
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;   // r0 keeps its reset value
        end
    end

    // Writeback value passes straight through to a same-cycle read
    always_comb begin
        readDataA = regs[readAddrA];
        readDataB = regs[readAddrB];
        if (writeEnable && writeAddr != '0 && writeAddr == readAddrA) begin
            readDataA = writeData;
        end
        if (writeEnable && writeAddr != '0 && writeAddr == readAddrB) begin
            readDataB = writeData;
        end
    end

    assert property (@(posedge clk) disable iff (reset) readAddrA == '0 |-> readDataA == '0)
        else $error("registerFile: r0 read back nonzero");

endmodule

`default_nettype wire

/* verilog/controlDecoder.sv */
`timescale 1ns/100ps
`default_nettype none

module controlDecoder (
    input  mipsPkg::instrT instr,
    output mipsPkg::ctrlT  ctrl,
    output logic           branch,
    output logic           jump
);

    always_comb begin
        ctrl   = '0;
        branch = 1'b0;
        jump   = 1'b0;
        case (instr.i.opcode)
            mipsPkg::OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                case (instr.r.funct)
                    mipsPkg::FN_ADD: ctrl.aluOp = mipsPkg::ALU_ADD;
                    mipsPkg::FN_SUB: ctrl.aluOp = mipsPkg::ALU_SUB;
                    mipsPkg::FN_AND: ctrl.aluOp = mipsPkg::ALU_AND;
                    mipsPkg::FN_OR:  ctrl.aluOp = mipsPkg::ALU_OR;
                    mipsPkg::FN_SLT: ctrl.aluOp = mipsPkg::ALU_SLT;
                    default:         ctrl.regWrite = 1'b0; // Unsupported funct or nop
                endcase
            end
            mipsPkg::OP_LW: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = mipsPkg::ALU_ADD;
            end
            mipsPkg::OP_SW: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = mipsPkg::ALU_ADD;
            end
            mipsPkg::OP_ADDI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = mipsPkg::ALU_ADD;
            end
            mipsPkg::OP_ORI: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrcImm  = 1'b1;
                ctrl.zeroExtend = 1'b1;
                ctrl.aluOp      = mipsPkg::ALU_OR;
            end
            mipsPkg::OP_LUI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;   // Selects rt as destination
                ctrl.immToReg  = 1'b1;
            end
            mipsPkg::OP_BEQ:  branch = 1'b1;
            mipsPkg::OP_J:    jump = 1'b1;
            mipsPkg::OP_HALT: ctrl.halt = 1'b1;
            default: ;                   // Unknown opcode decodes to nop
        endcase
    end

endmodule

`default_nettype wire

/* verilog/mipsPkg.sv */
`default_nettype none

`include "mipsCore_cfg.svh"

package mipsPkg;

    ////////////////////////////////////////////////////////////
    // Instruction encoding
    ////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_ORI   = 6'h0D,
        OP_HALT  = 6'h0E,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcodeT;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } functT;

    typedef struct packed {
        opcodeT                      opcode;
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        logic [`MIPS_REG_ADDR_W-1:0] rd;
        logic [4:0]                  shamt;
        functT                       funct;
    } rFormatT;

    // Jump target is the low 26 bits of this view
    typedef struct packed {
        opcodeT                      opcode;
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        logic [15:0]                 imm;
    } iFormatT;

    typedef union packed {
        rFormatT r;
        iFormatT i;
    } instrT;

    ////////////////////////////////////////////////////////////
    // Control and pipeline bundles
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_AND = 3'b000,
        ALU_OR  = 3'b001,
        ALU_ADD = 3'b010,
        ALU_SUB = 3'b110,
        ALU_SLT = 3'b111
    } aluOpT;

    // All zeros is a nop
    typedef struct packed {
        logic  regWrite;
        logic  memWrite;
        logic  memToReg;
        logic  immToReg;   // lui
        logic  aluSrcImm;
        logic  zeroExtend; // ori
        aluOpT aluOp;
        logic  halt;
    } ctrlT;

    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwdSelT;

    typedef struct packed {
        ctrlT                        ctrl;
        logic [`MIPS_XLEN-1:0]       opA;
        logic [`MIPS_XLEN-1:0]       opB;
        logic [`MIPS_XLEN-1:0]       imm;
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        logic [`MIPS_REG_ADDR_W-1:0] dest;
    } decExecT;

    typedef struct packed {
        ctrlT                        ctrl;
        logic [`MIPS_XLEN-1:0]       aluResult;
        logic [`MIPS_XLEN-1:0]       storeData;
        logic [`MIPS_REG_ADDR_W-1:0] dest;
    } execMemT;

    typedef struct packed {
        ctrlT                        ctrl;
        logic [`MIPS_XLEN-1:0]       aluResult;
        logic [`MIPS_XLEN-1:0]       loadData;
        logic [`MIPS_REG_ADDR_W-1:0] dest;
    } memWbT;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0] addr;
        logic [`MIPS_XLEN-1:0] writeData;
        logic                  write;
    } dataMemReqT;

endpackage

`default_nettype wire

/* include/mipsCore_cfg.svh */
`ifndef MIPS_CORE_CFG_SVH
`define MIPS_CORE_CFG_SVH

// Address of the first instruction fetched after reset
`define MIPS_RESET_PC 32'h0040_0000

`define MIPS_XLEN 32          // Datapath and register width
`define MIPS_REG_COUNT 32     // Architectural registers
`define MIPS_REG_ADDR_W 5     // Register index width

// Data address bits decoded by the external data memory
`define MIPS_MEM_ADDR_BITS 14

`endif
